// ==== logic/tiny_pipe_pkg.sv ====
package tiny_pipe_pkg;

  // Datapath and register file geometry
  localparam int XLEN      = 8;
  localparam int NREGS     = 4;
  localparam int REG_IDX_W = $clog2(NREGS);

  // Instruction word layout, from msb down: op, rd, rs, rt, imm
  localparam int INSTR_W = 16;
  localparam int OP_W    = 2;
  localparam int IMM_W   = 8;
  localparam int RT_LSB  = IMM_W;
  localparam int RS_LSB  = RT_LSB + REG_IDX_W;
  localparam int RD_LSB  = RS_LSB + REG_IDX_W;
  localparam int OP_LSB  = RD_LSB + REG_IDX_W;

  typedef enum logic [OP_W-1:0] {
    OP_ADDI = 2'd0,
    OP_ADD  = 2'd1,
    OP_SUB  = 2'd2,
    OP_SKZ  = 2'd3
  } op_e;

  // Decoded instruction held in the EX stage register
  typedef struct packed {
    op_e                  op;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs;
    logic [REG_IDX_W-1:0] rt;
    logic [IMM_W-1:0]     imm;
  } ex_payload_t;

  // Writeback target and value held in the WB stage register
  typedef struct packed {
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      result;
  } wb_payload_t;

endpackage

// ==== logic/pipe_data.sv ====
module pipe_data #(
  parameter type T          = logic,
  parameter bit  RESET_REG  = 1'b0,
  parameter T    RESET_VAL  = '0,
  parameter bit  FLUSH_REG  = 1'b0,
  parameter T    FLUSH_VAL  = '0,
  parameter bit  BUBBLE_REG = 1'b0,
  parameter T    BUBBLE_VAL = '0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic advance_i,
  input  logic flush_i,
  input  logic bubble_i,
  input  T     data_i,
  output T     data_o
);

  // Each kill event either forces its constant or just takes the input,
  // so payload registers need no extra mux in front of them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_o <= RESET_REG ? data_i : RESET_VAL;
    end else if (flush_i) begin
      data_o <= FLUSH_REG ? data_i : FLUSH_VAL;
    end else if (bubble_i) begin
      data_o <= BUBBLE_REG ? data_i : BUBBLE_VAL;
    end else if (advance_i) begin
      data_o <= data_i;
    end
  end

  // Controller must never ask for both kinds of kill in one cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(flush_i && bubble_i))
  else $error("pipe_data: flush and bubble asserted together");

endmodule

// ==== logic/instr_decode.sv ====
module instr_decode
  import tiny_pipe_pkg::*;
(
  input  logic [INSTR_W-1:0]   instr_i,
  output op_e                  op_o,
  output logic [REG_IDX_W-1:0] rd_o,
  output logic [REG_IDX_W-1:0] rs_o,
  output logic [REG_IDX_W-1:0] rt_o,
  output logic [IMM_W-1:0]     imm_o
);

  // Field positions come from the package so the encoding lives in one place
  assign op_o  = op_e'(instr_i[OP_LSB +: OP_W]);
  assign rd_o  = instr_i[RD_LSB +: REG_IDX_W];
  assign rs_o  = instr_i[RS_LSB +: REG_IDX_W];
  assign rt_o  = instr_i[RT_LSB +: REG_IDX_W];

  // Immediate sits in the low bits
  assign imm_o = instr_i[IMM_W-1:0];

endmodule

// ==== logic/reg_file.sv ====
module reg_file
  import tiny_pipe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we_i,
  input  logic [REG_IDX_W-1:0] waddr_i,
  input  logic [XLEN-1:0]      wdata_i,
  input  logic [REG_IDX_W-1:0] raddr_a_i,
  input  logic [REG_IDX_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]      rdata_a_o,
  output logic [XLEN-1:0]      rdata_b_o
);

  logic [XLEN-1:0] regs_q [NREGS];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads show the value before this cycle's write
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== logic/exec_unit.sv ====
module exec_unit
  import tiny_pipe_pkg::*;
(
  input  logic                 ex_valid_i,
  input  op_e                  op_i,
  input  logic [REG_IDX_W-1:0] rs_i,
  input  logic [REG_IDX_W-1:0] rt_i,
  input  logic [IMM_W-1:0]     imm_i,
  input  logic [XLEN-1:0]      rdata_a_i,
  input  logic [XLEN-1:0]      rdata_b_i,
  input  logic                 wb_valid_i,
  input  logic [REG_IDX_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]      wb_data_i,
  output logic [XLEN-1:0]      result_o,
  output logic                 writes_o,
  output logic                 skip_taken_o
);

  logic [XLEN-1:0] opnd_a;
  logic [XLEN-1:0] opnd_b;
  logic            fwd_a;
  logic            fwd_b;

  // WB writes the register file at the end of this cycle, so forward it
  assign fwd_a  = wb_valid_i && (wb_rd_i == rs_i);
  assign fwd_b  = wb_valid_i && (wb_rd_i == rt_i);
  assign opnd_a = fwd_a ? wb_data_i : rdata_a_i;
  assign opnd_b = fwd_b ? wb_data_i : rdata_b_i;

  always_comb begin
    case (op_i)
      OP_ADDI: result_o = opnd_a + XLEN'(imm_i);
      OP_ADD:  result_o = opnd_a + opnd_b;
      OP_SUB:  result_o = opnd_a - opnd_b;
      default: result_o = '0;
    endcase
  end

  // SKZ only steers control flow
  assign writes_o = (op_i != OP_SKZ);

  // Skip test uses the forwarded operand too
  assign skip_taken_o = ex_valid_i && (op_i == OP_SKZ) && (opnd_a == '0);

endmodule

// ==== logic/pipe_ctrl.sv ====
module pipe_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic hold_i,
  input  logic instr_valid_i,
  input  logic ex_valid_i,
  input  logic id_valid_i,
  input  logic skip_taken_i,
  output logic id_advance_o,
  output logic id_flush_o,
  output logic id_bubble_o,
  output logic ex_advance_o,
  output logic ex_bubble_o,
  output logic wb_advance_o,
  output logic wb_bubble_o
);

  logic skip_pending_q;
  logic skip_go;
  logic skip_arm;

  // SKZ acts only on the cycle it leaves EX
  assign skip_go = skip_taken_i && ex_valid_i && !hold_i;

  // Victim is either in ID now or is the next strobe to arrive
  assign skip_arm = skip_pending_q || (skip_go && !id_valid_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skip_pending_q <= 1'b0;
    end else begin
      skip_pending_q <= skip_arm && !instr_valid_i;
    end
  end

  assign id_advance_o = !hold_i;
  assign ex_advance_o = !hold_i;
  assign wb_advance_o = !hold_i;

  // Victim in ID gets replaced by a bubble on its way into EX
  assign ex_bubble_o = skip_go && id_valid_i;

  // ID is emptied outright when no new strobe refills it
  assign id_flush_o  = skip_go && id_valid_i && !instr_valid_i;

  // Incoming victim strobe is captured as a bubble
  assign id_bubble_o = skip_arm && instr_valid_i;

  // Hold freezes ID and EX, so WB must not repeat its last entry
  assign wb_bubble_o = hold_i;

  assert property (@(posedge clk) disable iff (!rst_n)
    hold_i |-> !instr_valid_i)
  else $error("pipe_ctrl: instruction strobe during hold");

  // A pending skip means ID was empty, so EX stays empty until the victim
  assert property (@(posedge clk) disable iff (!rst_n)
    skip_pending_q |-> !ex_valid_i)
  else $error("pipe_ctrl: EX valid while a skip is pending");

endmodule

// ==== logic/tiny_pipe_top.sv ====
module tiny_pipe_top
  import tiny_pipe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid_i,
  input  logic [INSTR_W-1:0]   instr_i,
  input  logic                 hold_i,
  output logic                 wb_valid_o,
  output logic [REG_IDX_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]      wb_data_o
);

  logic id_advance;
  logic id_flush;
  logic id_bubble;
  logic ex_advance;
  logic ex_bubble;
  logic wb_advance;
  logic wb_bubble;

  logic               id_valid;
  logic [INSTR_W-1:0] id_instr;
  logic               ex_valid;
  ex_payload_t        ex_d;
  ex_payload_t        ex_q;
  logic               wb_valid;
  wb_payload_t        wb_d;
  wb_payload_t        wb_q;

  op_e                  dec_op;
  logic [REG_IDX_W-1:0] dec_rd;
  logic [REG_IDX_W-1:0] dec_rs;
  logic [REG_IDX_W-1:0] dec_rt;
  logic [IMM_W-1:0]     dec_imm;

  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] ex_result;
  logic            ex_writes;
  logic            skip_taken;

  pipe_ctrl u_pipe_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold_i       (hold_i),
    .instr_valid_i(instr_valid_i),
    .ex_valid_i   (ex_valid),
    .id_valid_i   (id_valid),
    .skip_taken_i (skip_taken),
    .id_advance_o (id_advance),
    .id_flush_o   (id_flush),
    .id_bubble_o  (id_bubble),
    .ex_advance_o (ex_advance),
    .ex_bubble_o  (ex_bubble),
    .wb_advance_o (wb_advance),
    .wb_bubble_o  (wb_bubble)
  );

  // ID stage holds the raw instruction word
  pipe_data #(.T(logic)) u_id_valid (
    .clk(clk), .rst_n(rst_n), .advance_i(id_advance), .flush_i(id_flush),
    .bubble_i(id_bubble), .data_i(instr_valid_i), .data_o(id_valid)
  );

  pipe_data #(
    .T(logic [INSTR_W-1:0]), .RESET_REG(1'b1), .FLUSH_REG(1'b1), .BUBBLE_REG(1'b1)
  ) u_id_data (
    .clk(clk), .rst_n(rst_n), .advance_i(id_advance), .flush_i(id_flush),
    .bubble_i(id_bubble), .data_i(instr_i), .data_o(id_instr)
  );

  instr_decode u_instr_decode (
    .instr_i(id_instr),
    .op_o   (dec_op),
    .rd_o   (dec_rd),
    .rs_o   (dec_rs),
    .rt_o   (dec_rt),
    .imm_o  (dec_imm)
  );

  assign ex_d = '{op: dec_op, rd: dec_rd, rs: dec_rs, rt: dec_rt, imm: dec_imm};

  // EX stage never flushes itself, skips reach it as bubbles
  pipe_data #(.T(logic)) u_ex_valid (
    .clk(clk), .rst_n(rst_n), .advance_i(ex_advance), .flush_i(1'b0),
    .bubble_i(ex_bubble), .data_i(id_valid && !id_flush), .data_o(ex_valid)
  );

  pipe_data #(
    .T(ex_payload_t), .RESET_REG(1'b1), .FLUSH_REG(1'b1), .BUBBLE_REG(1'b1)
  ) u_ex_data (
    .clk(clk), .rst_n(rst_n), .advance_i(ex_advance), .flush_i(1'b0),
    .bubble_i(ex_bubble), .data_i(ex_d), .data_o(ex_q)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .we_i     (wb_valid),
    .waddr_i  (wb_q.rd),
    .wdata_i  (wb_q.result),
    .raddr_a_i(ex_q.rs),
    .raddr_b_i(ex_q.rt),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  exec_unit u_exec_unit (
    .ex_valid_i  (ex_valid),
    .op_i        (ex_q.op),
    .rs_i        (ex_q.rs),
    .rt_i        (ex_q.rt),
    .imm_i       (ex_q.imm),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .wb_valid_i  (wb_valid),
    .wb_rd_i     (wb_q.rd),
    .wb_data_i   (wb_q.result),
    .result_o    (ex_result),
    .writes_o    (ex_writes),
    .skip_taken_o(skip_taken)
  );

  assign wb_d = '{rd: ex_q.rd, result: ex_result};

  // Only register writers occupy WB
  pipe_data #(.T(logic)) u_wb_valid (
    .clk(clk), .rst_n(rst_n), .advance_i(wb_advance), .flush_i(1'b0),
    .bubble_i(wb_bubble), .data_i(ex_valid && ex_writes), .data_o(wb_valid)
  );

  pipe_data #(
    .T(wb_payload_t), .RESET_REG(1'b1), .FLUSH_REG(1'b1), .BUBBLE_REG(1'b1)
  ) u_wb_data (
    .clk(clk), .rst_n(rst_n), .advance_i(wb_advance), .flush_i(1'b0),
    .bubble_i(wb_bubble), .data_i(wb_d), .data_o(wb_q)
  );

  assign wb_valid_o = wb_valid;
  assign wb_rd_o    = wb_q.rd;
  assign wb_data_o  = wb_q.result;

endmodule

// ==== dv/tiny_pipe_tb.sv ====
module tiny_pipe_tb
  import tiny_pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {SLOT_IDLE, SLOT_INSTR, SLOT_HOLD} slot_e;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid_i;
  logic [INSTR_W-1:0]   instr_i;
  logic                 hold_i;
  logic                 wb_valid_o;
  logic [REG_IDX_W-1:0] wb_rd_o;
  logic [XLEN-1:0]      wb_data_o;

  // One schedule slot per stimulus cycle
  slot_e                     slot_q[$];
  logic [INSTR_W-1:0]        word_q[$];
  // Expected writebacks as {rd, data}
  logic [REG_IDX_W+XLEN-1:0] exp_q[$];
  logic [REG_IDX_W+XLEN-1:0] exp_entry;
  logic [XLEN-1:0]           model_regs [NREGS];
  logic                      model_skip;
  logic                      strobe_seen;
  int                        error_cnt;
  int                        check_cnt;
  int                        cycle_cnt;
  int                        timeout_limit;

  tiny_pipe_top u_tiny_pipe_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .hold_i       (hold_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Word layout is op, rd, rs, rt, imm from the msb down
  function automatic logic [INSTR_W-1:0] encode(input op_e op, input logic [1:0] rd, rs, rt,
                                                input logic [7:0] imm);
    return {op, rd, rs, rt, imm};
  endfunction

  // Program-order model of the ISA, a taken SKZ drops the next instruction
  function automatic void ref_exec(input logic [INSTR_W-1:0] w);
    op_e             op;
    logic [1:0]      rd;
    logic [1:0]      rs;
    logic [1:0]      rt;
    logic [XLEN-1:0] res;
    op = op_e'(w[15:14]);
    rd = w[13:12];
    rs = w[11:10];
    rt = w[9:8];
    if (model_skip) begin
      model_skip = 1'b0;
    end else if (op == OP_SKZ) begin
      model_skip = (model_regs[rs] == '0);
    end else begin
      case (op)
        OP_ADDI: res = model_regs[rs] + w[7:0];
        OP_ADD:  res = model_regs[rs] + model_regs[rt];
        default: res = model_regs[rs] - model_regs[rt];
      endcase
      model_regs[rd] = res;
      exp_q.push_back({rd, res});
    end
  endfunction

  task automatic queue_instr(input op_e op, input logic [1:0] rd, rs, rt, input logic [7:0] imm);
    logic [INSTR_W-1:0] w;
    w = encode(op, rd, rs, rt, imm);
    slot_q.push_back(SLOT_INSTR);
    word_q.push_back(w);
    ref_exec(w);
  endtask

  // Idle and hold slots carry junk on instr_i
  task automatic add_slots(input slot_e kind, input int n);
    repeat (n) begin
      slot_q.push_back(kind);
      word_q.push_back(16'($urandom));
    end
  endtask

  task automatic build_directed();
    add_slots(SLOT_IDLE, 6);
    // Dependent chain through the WB bypass
    queue_instr(OP_ADDI, 2'd0, 2'd0, 2'd0, 8'd5);
    queue_instr(OP_ADDI, 2'd1, 2'd0, 2'd0, 8'd3);
    queue_instr(OP_ADD,  2'd2, 2'd0, 2'd1, 8'd0);
    queue_instr(OP_SUB,  2'd3, 2'd2, 2'd0, 8'd0);
    queue_instr(OP_SUB,  2'd0, 2'd0, 2'd0, 8'd0);
    queue_instr(OP_ADD,  2'd1, 2'd1, 2'd3, 8'd0);
    add_slots(SLOT_IDLE, 4);
    // Taken skips with the victim 0, 1 and 3 cycles behind
    queue_instr(OP_SKZ,  2'd0, 2'd0, 2'd0, 8'd0);
    queue_instr(OP_ADDI, 2'd2, 2'd2, 2'd0, 8'd1);
    queue_instr(OP_ADDI, 2'd3, 2'd3, 2'd0, 8'd7);
    queue_instr(OP_SKZ,  2'd0, 2'd0, 2'd0, 8'd0);
    add_slots(SLOT_IDLE, 1);
    queue_instr(OP_ADDI, 2'd2, 2'd2, 2'd0, 8'd9);
    queue_instr(OP_ADDI, 2'd1, 2'd1, 2'd0, 8'd1);
    queue_instr(OP_SKZ,  2'd0, 2'd0, 2'd0, 8'd0);
    add_slots(SLOT_IDLE, 3);
    queue_instr(OP_ADDI, 2'd2, 2'd2, 2'd0, 8'd9);
    add_slots(SLOT_IDLE, 2);
    queue_instr(OP_ADDI, 2'd1, 2'd1, 2'd0, 8'd1);
    // Not taken, then a zero produced just before the SKZ, then SKZ as victim
    queue_instr(OP_SKZ,  2'd0, 2'd1, 2'd0, 8'd0);
    queue_instr(OP_ADDI, 2'd2, 2'd2, 2'd0, 8'd2);
    queue_instr(OP_SUB,  2'd3, 2'd3, 2'd3, 8'd0);
    queue_instr(OP_SKZ,  2'd0, 2'd3, 2'd0, 8'd0);
    queue_instr(OP_ADDI, 2'd0, 2'd0, 2'd0, 8'd4);
    queue_instr(OP_SKZ,  2'd0, 2'd3, 2'd0, 8'd0);
    queue_instr(OP_SKZ,  2'd0, 2'd1, 2'd0, 8'd0);
    queue_instr(OP_ADDI, 2'd0, 2'd0, 2'd0, 8'd6);
    add_slots(SLOT_IDLE, 4);
    // Hold windows between dependent work and around a skip
    queue_instr(OP_ADDI, 2'd0, 2'd0, 2'd0, 8'd1);
    add_slots(SLOT_HOLD, 3);
    queue_instr(OP_ADD,  2'd1, 2'd0, 2'd0, 8'd0);
    add_slots(SLOT_HOLD, 1);
    queue_instr(OP_SUB,  2'd2, 2'd1, 2'd0, 8'd0);
    add_slots(SLOT_IDLE, 1);
    add_slots(SLOT_HOLD, 2);
    queue_instr(OP_SUB,  2'd3, 2'd3, 2'd3, 8'd0);
    add_slots(SLOT_HOLD, 2);
    queue_instr(OP_SKZ,  2'd0, 2'd3, 2'd0, 8'd0);
    add_slots(SLOT_HOLD, 3);
    queue_instr(OP_ADDI, 2'd0, 2'd0, 2'd0, 8'd100);
    queue_instr(OP_ADDI, 2'd1, 2'd1, 2'd0, 8'd1);
    add_slots(SLOT_IDLE, 4);
  endtask

  task automatic build_random(input int count);
    op_e        op;
    logic [7:0] imm;
    for (int i = 0; i < count; i++) begin
      op  = op_e'(2'($urandom_range(0, 3)));
      imm = ($urandom_range(0, 3) == 0) ? 8'd0 : 8'($urandom_range(1, 255));
      queue_instr(op, 2'($urandom_range(0, 3)), 2'($urandom_range(0, 3)),
                  2'($urandom_range(0, 3)), imm);
      add_slots(SLOT_IDLE, int'($urandom_range(0, 3)));
      if ($urandom_range(0, 4) == 0) begin
        add_slots(SLOT_HOLD, int'($urandom_range(1, 4)));
      end
    end
  endtask

  // Compare every writeback against the model in order
  always @(posedge clk) begin
    if (rst_n && wb_valid_o) begin
      if (!strobe_seen) begin
        $display("FAILED at %0t: writeback rd=%0d data=0x%02h before any instruction",
                 $time, wb_rd_o, wb_data_o);
        error_cnt = error_cnt + 1;
      end else if (exp_q.size() == 0) begin
        $display("FAILED at %0t: unexpected writeback rd=%0d data=0x%02h",
                 $time, wb_rd_o, wb_data_o);
        error_cnt = error_cnt + 1;
      end else begin
        exp_entry = exp_q.pop_front();
        check_cnt = check_cnt + 1;
        if ({wb_rd_o, wb_data_o} != exp_entry) begin
          $display("FAILED at %0t: writeback rd=%0d data=0x%02h, expected rd=%0d data=0x%02h",
                   $time, wb_rd_o, wb_data_o, exp_entry[XLEN+:REG_IDX_W], exp_entry[XLEN-1:0]);
          error_cnt = error_cnt + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_limit) begin
        $display("Timeout after %0d cycles with %0d writebacks still missing, %0d errors",
                 cycle_cnt, exp_q.size(), error_cnt);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(41));
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    hold_i        = 1'b0;
    error_cnt     = 0;
    check_cnt     = 0;
    cycle_cnt     = 0;
    model_skip    = 1'b0;
    strobe_seen   = 1'b0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    build_directed();
    build_random(300);
    add_slots(SLOT_IDLE, 8);
    timeout_limit = 2 * slot_q.size() + 50;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (slot_q[i]) begin
      @(negedge clk);
      instr_valid_i = (slot_q[i] == SLOT_INSTR);
      hold_i        = (slot_q[i] == SLOT_HOLD);
      instr_i       = word_q[i];
      if (slot_q[i] == SLOT_INSTR) begin
        strobe_seen = 1'b1;
      end
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
    hold_i        = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end

    $display("Writebacks checked: %0d, errors: %0d, still expected: %0d",
             check_cnt, error_cnt, exp_q.size());
    if (error_cnt == 0 && exp_q.size() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tiny_pipe.f ====
logic/tiny_pipe_pkg.sv
logic/pipe_data.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/pipe_ctrl.sv
logic/tiny_pipe_top.sv
dv/tiny_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tiny_pipe_tb \
  -f tiny_pipe.f -o tiny_pipe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tiny_pipe_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation executable exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
